// File: project.f
+incdir+.
dnc_read_modes_pkg.sv
dnc_mode_control.sv
dnc_mode_capture.sv
dnc_mode_exp.sv
dnc_mode_recip.sv
dnc_mode_normalize.sv
dnc_read_modes.sv
dnc_read_modes_tb.sv

// File: Bender.yml
package:
  name: dnc_read_modes

sources:
  - include_dirs:
      - .
    files:
      - dnc_read_modes_pkg.sv
      - dnc_mode_control.sv
      - dnc_mode_capture.sv
      - dnc_mode_exp.sv
      - dnc_mode_recip.sv
      - dnc_mode_normalize.sv
      - dnc_read_modes.sv
  - target: test
    include_dirs:
      - .
    files:
      - dnc_read_modes_tb.sv

// File: dnc_read_modes_tb.sv
// DNC read modes testbench: serial softmax outputs against a fixed point reference model
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_read_modes_tb;

  // Heads over all tests, sets the watchdog
  localparam int TOTAL_HEADS     = 36;
  localparam int WATCHDOG_CYCLES = TOTAL_HEADS * 40 + 200;

  typedef logic [`DNC_MODES-1:0][`DNC_SCORE_W-1:0] scores_t;
  typedef logic [`DNC_MODES-1:0][`DNC_PI_W-1:0]    modes_t;

  logic                    clk;
  logic                    reset;
  logic                    start;
  logic [`DNC_HEADS_W-1:0] size_r_in;
  logic [`DNC_SCORE_W-1:0] pi_in;
  logic                    pi_in_i_enable;
  logic                    pi_in_p_enable;
  logic                    ready;
  logic [`DNC_PI_W-1:0]    pi_out;
  logic                    pi_out_i_enable;
  logic                    pi_out_p_enable;

  integer seed          = 32'h0100adbf;
  int     errors        = 0;
  int     checks        = 0;
  int     tests_run     = 0;
  int     tests_failed  = 0;
  int     test_err_base = 0;
  int     heads_out     = 0;
  int     out_p         = 0;

  // Expected modes in output order, heads of the next job
  logic [`DNC_PI_W-1:0] exp_q [$];
  scores_t              job_scores [$];

  dnc_read_modes uut (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .size_r_in       (size_r_in),
    .pi_in           (pi_in),
    .pi_in_i_enable  (pi_in_i_enable),
    .pi_in_p_enable  (pi_in_p_enable),
    .ready           (ready),
    .pi_out          (pi_out),
    .pi_out_i_enable (pi_out_i_enable),
    .pi_out_p_enable (pi_out_p_enable)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////

  // Softmax of one triple, base-2 table path
  function automatic modes_t modes_ref(input scores_t s);
    modes_t r;
    longint m;
    longint neg_prod;
    longint u;
    longint e [`DNC_MODES];
    longint sum;
    longint recip;
    longint q;
    m = $signed(s[0]);
    for (int p = 1; p < `DNC_MODES; p++) begin
      if ($signed(s[p]) > m) begin
        m = $signed(s[p]);
      end
    end
    sum = 0;
    for (int p = 0; p < `DNC_MODES; p++) begin
      // -(d * log2e), never negative
      neg_prod = (m - $signed(s[p])) * `DNC_LOG2E;
      // u = -floor(d * log2e / 256)
      u = (neg_prod + 255) / 256;
      if (u / 256 >= `DNC_EXP_W) begin
        e[p] = 0;
      end else begin
        e[p] = dnc_read_modes_pkg::pow2_lut[(u % 256) / 16] >> (u / 256);
      end
      sum += e[p];
    end
    recip = (longint'(1) << 32) / sum;
    for (int p = 0; p < `DNC_MODES; p++) begin
      q = (e[p] * recip) / 65536;
      // Clip at the top of Q0.16
      if (q > 65535) begin
        q = 65535;
      end
      r[p] = q[`DNC_PI_W-1:0];
    end
    return r;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  // Mostly within +-6.0, now and then anywhere in Q8.8
  function automatic logic [`DNC_SCORE_W-1:0] random_score();
    integer r;
    r = $random(seed);
    if (r[31:29] == 3'b000) begin
      return r[`DNC_SCORE_W-1:0];
    end
    return `DNC_SCORE_W'(r % 1536);
  endfunction

  function automatic int random_gap(input int max_gap);
    return {$random(seed)} % (max_gap + 1);
  endfunction

  // Three scores in p order, idle gaps between them
  task automatic send_head(input scores_t s, input int max_gap);
    for (int p = 0; p < `DNC_MODES; p++) begin
      if (p > 0) begin
        repeat (random_gap(max_gap)) @(negedge clk);
      end
      pi_in          = s[p];
      pi_in_p_enable = 1'b1;
      pi_in_i_enable = (p == 0);
      @(negedge clk);
      pi_in_p_enable = 1'b0;
      pi_in_i_enable = 1'b0;
    end
  endtask

  // One job over job_scores, paced by pi_out_i_enable
  task automatic run_job(input int max_gap, input bit push_ref);
    int     n;
    int     base_out;
    modes_t m;
    n        = job_scores.size();
    base_out = heads_out;
    start     = 1'b1;
    size_r_in = `DNC_HEADS_W'(n);
    @(negedge clk);
    start = 1'b0;
    check_value(ready, 0, "ready low after start");
    for (int h = 0; h < n; h++) begin
      // Previous head has started to come out
      if (h > 0) begin
        while (!pi_out_i_enable) begin
          @(negedge clk);
        end
        check_value(ready, 0, "ready low during job");
      end
      if (push_ref) begin
        m = modes_ref(job_scores[h]);
        for (int p = 0; p < `DNC_MODES; p++) begin
          exp_q.push_back(m[p]);
        end
      end
      send_head(job_scores[h], max_gap);
    end
    while (!ready) begin
      @(negedge clk);
    end
    check_value(heads_out - base_out, n, "output heads in job");
    check_value(exp_q.size(), 0, "expected modes left over");
    job_scores.delete();
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors != test_err_base) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err_base);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    test_err_base = errors;
  endtask

  ////////////////////
  // Output compare
  ////////////////////

  // Outputs change on the rising edge, sampled on the falling one
  always @(negedge clk) begin
    if (!reset && pi_out_p_enable) begin
      check_value(pi_out_i_enable, out_p == 0, "pi_out_i_enable with first mode");
      check_value(ready, 0, "ready low while modes come out");
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR at %0t ns: mode %0d came out with no head sent for it", $time, pi_out);
      end else begin
        check_value(pi_out, exp_q.pop_front(), $sformatf("mode p=%0d", out_p));
      end
      if (out_p == 0) begin
        heads_out++;
      end
      out_p = (out_p == `DNC_MODES - 1) ? 0 : out_p + 1;
    end else if (!reset && pi_out_i_enable) begin
      errors++;
      $display("ERROR at %0t ns: pi_out_i_enable high without pi_out_p_enable", $time);
    end
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int stray_base;
    clk            = 1'b0;
    reset          = 1'b1;
    start          = 1'b0;
    size_r_in      = '0;
    pi_in          = '0;
    pi_in_i_enable = 1'b0;
    pi_in_p_enable = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Reset state, then equal scores split evenly
    check_value(ready, 1, "ready after reset");
    check_value(pi_out_p_enable, 0, "pi_out_p_enable after reset");
    check_value(pi_out_i_enable, 0, "pi_out_i_enable after reset");
    job_scores.push_back({16'h0180, 16'h0180, 16'h0180});
    repeat (3) exp_q.push_back(16'd21845);
    run_job(0, 1'b0);
    report_test("reset and equal scores");

    // Content 16.0 above the rest, saturates to one
    job_scores.push_back({16'hf800, 16'h0800, 16'hf800});
    exp_q.push_back(16'd0);
    exp_q.push_back(16'd65535);
    exp_q.push_back(16'd0);
    run_job(0, 1'b0);
    report_test("dominant score");

    // Paced random heads
    for (int h = 0; h < 20; h++) begin
      job_scores.push_back({random_score(), random_score(), random_score()});
    end
    run_job(0, 1'b1);
    report_test("20 random heads");

    // Ready held low across a short job
    for (int h = 0; h < 4; h++) begin
      job_scores.push_back({16'h0100, `DNC_SCORE_W'(-h * 150), `DNC_SCORE_W'(h * 200)});
    end
    run_job(0, 1'b1);
    report_test("ready and head count");

    // Scores outside a job, then an empty job
    stray_base = heads_out;
    send_head({random_score(), random_score(), random_score()}, 0);
    repeat (40) @(negedge clk);
    check_value(heads_out - stray_base, 0, "outputs from stray scores");
    check_value(ready, 1, "ready still high after stray scores");
    run_job(0, 1'b1);
    report_test("idle scores and empty job");

    // Gaps of 0 to 5 cycles between scores
    for (int h = 0; h < 10; h++) begin
      job_scores.push_back({random_score(), random_score(), random_score()});
    end
    run_job(5, 1'b1);
    report_test("gaps between scores");

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dnc_read_modes.sv
// DNC read modes top: softmax over three mode scores per read head
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_read_modes (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    start,
  input  wire [`DNC_HEADS_W-1:0] size_r_in,
  input  wire [`DNC_SCORE_W-1:0] pi_in,
  input  wire                    pi_in_i_enable,
  input  wire                    pi_in_p_enable,
  output logic                   ready,
  output logic [`DNC_PI_W-1:0]   pi_out,
  output logic                   pi_out_i_enable,
  output logic                   pi_out_p_enable
);

  ////////////////////
  // Stage links
  ////////////////////

  logic job_active;
  logic head_done;

  dnc_read_modes_pkg::mode_triple_t triple;
  logic                             triple_valid;
  dnc_read_modes_pkg::mode_exp_t    exps;
  logic                             exp_valid;
  dnc_read_modes_pkg::mode_norm_t   norm;
  logic                             norm_valid;

  // Job count and ready
  dnc_mode_control u_control (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .size_r_in  (size_r_in),
    .head_done  (head_done),
    .job_active (job_active),
    .ready      (ready)
  );

  // Scores in, triple and max out
  dnc_mode_capture u_capture (
    .clk            (clk),
    .reset          (reset),
    .job_active     (job_active),
    .pi_in_i_enable (pi_in_i_enable),
    .pi_in_p_enable (pi_in_p_enable),
    .pi_in          (pi_in),
    .triple         (triple),
    .triple_valid   (triple_valid)
  );

  // 2^(log2e * (s - max))
  dnc_mode_exp u_exp (
    .clk          (clk),
    .reset        (reset),
    .triple       (triple),
    .triple_valid (triple_valid),
    .exps         (exps),
    .exp_valid    (exp_valid)
  );

  // 1 / sum, 19 cycles
  dnc_mode_recip u_recip (
    .clk        (clk),
    .reset      (reset),
    .exps       (exps),
    .exp_valid  (exp_valid),
    .norm       (norm),
    .norm_valid (norm_valid)
  );

  // Modes out, p = 0 first
  dnc_mode_normalize u_normalize (
    .clk             (clk),
    .reset           (reset),
    .norm            (norm),
    .norm_valid      (norm_valid),
    .pi_out          (pi_out),
    .pi_out_i_enable (pi_out_i_enable),
    .pi_out_p_enable (pi_out_p_enable),
    .head_done       (head_done)
  );

endmodule

`default_nettype wire

// File: dnc_mode_normalize.sv
// DNC read modes stage 4: scales exponents by the reciprocal and emits modes serially
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_mode_normalize (
  input  wire                            clk,
  input  wire                            reset,
  input  dnc_read_modes_pkg::mode_norm_t norm,
  input  wire                            norm_valid,
  output logic [`DNC_PI_W-1:0]           pi_out,
  output logic                           pi_out_i_enable,
  output logic                           pi_out_p_enable,
  output logic                           head_done
);

  localparam int MUL_W  = 2 * `DNC_EXP_W;
  localparam int ONE_W  = `DNC_EXP_W - 1;
  localparam int SLOT_W = $clog2(`DNC_MODES);
  localparam logic [SLOT_W-1:0] LAST = SLOT_W'(`DNC_MODES - 1);

  logic [MUL_W-1:0]                        prod_c [`DNC_MODES];
  logic [MUL_W-ONE_W-1:0]                  scaled_c [`DNC_MODES];
  logic [`DNC_MODES-1:0][`DNC_PI_W-1:0]    sat_c;
  logic [`DNC_MODES-1:0][`DNC_PI_W-1:0]    vals;
  logic [SLOT_W-1:0]                       slot;
  logic                                    emitting;

  // floor(e * recip / 65536), clipped to Q0.16
  always_comb begin
    for (int p = 0; p < `DNC_MODES; p++) begin
      prod_c[p]   = MUL_W'(norm.exps.e[p]) * MUL_W'(norm.recip);
      scaled_c[p] = prod_c[p][MUL_W-1:ONE_W];
      sat_c[p]    = (scaled_c[p] > {`DNC_PI_W{1'b1}}) ? {`DNC_PI_W{1'b1}}
                                                      : scaled_c[p][`DNC_PI_W-1:0];
    end
  end

  // Output strobes and slot counter
  always_ff @(posedge clk) begin
    if (reset) begin
      emitting        <= 1'b0;
      slot            <= '0;
      pi_out_p_enable <= 1'b0;
      pi_out_i_enable <= 1'b0;
      head_done       <= 1'b0;
    end else begin
      pi_out_p_enable <= emitting;
      pi_out_i_enable <= emitting && (slot == '0);
      head_done       <= emitting && (slot == LAST);
      if (norm_valid) begin
        emitting <= 1'b1;
        slot     <= '0;
      end else if (emitting) begin
        slot <= slot + 1'b1;
        if (slot == LAST) emitting <= 1'b0;
      end
    end
  end

  // Registered products, then one mode per cycle in p order
  always_ff @(posedge clk) begin
    if (norm_valid) vals <= sat_c;
    if (emitting) pi_out <= vals[slot];
  end

endmodule

`default_nettype wire

// File: dnc_mode_recip.sv
// DNC read modes stage 3: sum of exponents and its reciprocal by restoring division
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_mode_recip (
  input  wire                            clk,
  input  wire                            reset,
  input  dnc_read_modes_pkg::mode_exp_t  exps,
  input  wire                            exp_valid,
  output dnc_read_modes_pkg::mode_norm_t norm,
  output logic                           norm_valid
);

  localparam int SUM_W = `DNC_EXP_W + 2;
  localparam int REM_W = SUM_W + 1;
  localparam int CNT_W = $clog2(`DNC_RECIP_STEPS + 1);
  // Dividend is 2^32, one 1.0 times another
  localparam int DIVIDEND_LOG2 = 2 * (`DNC_EXP_W - 1);
  // Upper dividend bits give this first partial remainder
  localparam logic [REM_W-1:0] REM_INIT = REM_W'(1) << (DIVIDEND_LOG2 - `DNC_RECIP_STEPS);

  logic [SUM_W-1:0]      sum_c;
  logic [SUM_W-1:0]      sum_q;
  logic [REM_W-1:0]      rem;
  logic [REM_W-1:0]      rem_sh;
  logic [REM_W-1:0]      rem_next;
  logic [`DNC_EXP_W-1:0] quot;
  logic                  fits;
  logic [CNT_W-1:0]      step_cnt;
  logic                  busy;
  dnc_read_modes_pkg::mode_exp_t exps_q;

  // Max term is 65536, so sum stays within 65536..196608
  always_comb begin
    sum_c = '0;
    for (int p = 0; p < `DNC_MODES; p++) begin
      sum_c = sum_c + SUM_W'(exps.e[p]);
    end
  end

  // One quotient bit per step, remaining dividend bits are zero
  always_comb begin
    rem_sh   = {rem[REM_W-2:0], 1'b0};
    fits     = rem_sh >= REM_W'(sum_q);
    rem_next = fits ? rem_sh - REM_W'(sum_q) : rem_sh;
  end

  // Divider sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      step_cnt   <= '0;
      norm_valid <= 1'b0;
    end else begin
      norm_valid <= 1'b0;
      if (exp_valid) begin
        busy     <= 1'b1;
        step_cnt <= CNT_W'(`DNC_RECIP_STEPS);
      end else if (busy) begin
        if (step_cnt != '0) begin
          step_cnt <= step_cnt - 1'b1;
        end else begin
          busy       <= 1'b0;
          norm_valid <= 1'b1;
        end
      end
    end
  end

  // Datapath, exponents parked beside the quotient
  always_ff @(posedge clk) begin
    if (exp_valid) begin
      sum_q  <= sum_c;
      exps_q <= exps;
      rem    <= REM_INIT;
      quot   <= '0;
    end else if (busy && step_cnt != '0) begin
      rem  <= rem_next;
      quot <= {quot[`DNC_EXP_W-2:0], fits};
    end else if (busy) begin
      norm.exps  <= exps_q;
      norm.recip <= quot;
    end
  end

  // Pacing keeps one head in the divider at a time
  a_no_overrun : assert property (
    @(posedge clk) disable iff (reset) exp_valid |-> !busy
  ) else $error("exponents arrived while the divider is busy");

endmodule

`default_nettype wire

// File: dnc_mode_exp.sv
// DNC read modes stage 2: base-2 exponent of each score relative to the maximum
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_mode_exp (
  input  wire                              clk,
  input  wire                              reset,
  input  dnc_read_modes_pkg::mode_triple_t triple,
  input  wire                              triple_valid,
  output dnc_read_modes_pkg::mode_exp_t    exps,
  output logic                             exp_valid
);

  localparam int DIFF_W = `DNC_SCORE_W + 1;
  localparam int COEF_W = 12;
  localparam int PROD_W = DIFF_W + COEF_W;
  localparam int FRAC_W = 8;
  localparam logic signed [COEF_W-1:0] LOG2E_S = `DNC_LOG2E;

  logic signed [DIFF_W-1:0] diff_c [`DNC_MODES];
  logic signed [PROD_W-1:0] prod_c [`DNC_MODES];
  logic signed [PROD_W-1:0] prod_q [`DNC_MODES];
  logic        [PROD_W-1:0] mag_c  [`DNC_MODES];
  logic        [PROD_W-1:0] shift_c [`DNC_MODES];
  logic        [`DNC_EXP_W-1:0] e_c [`DNC_MODES];
  logic prod_valid;

  // d = score - max, never positive, scaled by log2(e)
  always_comb begin
    for (int p = 0; p < `DNC_MODES; p++) begin
      diff_c[p] = $signed({triple.score[p][`DNC_SCORE_W-1], triple.score[p]})
                - $signed({triple.score_max[`DNC_SCORE_W-1], triple.score_max});
      prod_c[p] = diff_c[p] * LOG2E_S;
    end
  end

  // u = -floor(d * log2e / 256), table picks the fraction and the rest shifts
  always_comb begin
    for (int p = 0; p < `DNC_MODES; p++) begin
      mag_c[p]   = -(prod_q[p] >>> FRAC_W);
      shift_c[p] = mag_c[p] >> FRAC_W;
      if (shift_c[p] >= `DNC_EXP_W) begin
        e_c[p] = '0;
      end else begin
        e_c[p] = dnc_read_modes_pkg::pow2_lut[mag_c[p][FRAC_W-1:FRAC_W-4]] >> shift_c[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      exp_valid  <= 1'b0;
    end else begin
      prod_valid <= triple_valid;
      exp_valid  <= prod_valid;
    end
  end

  // Payload pipe, product then shifted result
  always_ff @(posedge clk) begin
    for (int p = 0; p < `DNC_MODES; p++) begin
      if (triple_valid) prod_q[p] <= prod_c[p];
      if (prod_valid) exps.e[p] <= e_c[p];
    end
  end

endmodule

`default_nettype wire

// File: dnc_mode_capture.sv
// DNC read modes stage 1: gathers three scores of a head and tracks their maximum
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_mode_capture (
  input  wire                               clk,
  input  wire                               reset,
  input  wire                               job_active,
  input  wire                               pi_in_i_enable,
  input  wire                               pi_in_p_enable,
  input  wire [`DNC_SCORE_W-1:0]            pi_in,
  output dnc_read_modes_pkg::mode_triple_t  triple,
  output logic                              triple_valid
);

  localparam int IDX_W = $clog2(`DNC_MODES);
  localparam logic [IDX_W-1:0] LAST = IDX_W'(`DNC_MODES - 1);

  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] elem;
  logic             sample;
  logic             last_seen;

  // Head strobe forces element 0
  always_comb begin
    elem   = pi_in_i_enable ? '0 : idx;
    sample = job_active && pi_in_p_enable;
  end

  // Element index and the valid pipe
  always_ff @(posedge clk) begin
    if (reset) begin
      idx          <= '0;
      last_seen    <= 1'b0;
      triple_valid <= 1'b0;
    end else begin
      last_seen    <= sample && (elem == LAST);
      triple_valid <= last_seen;
      if (sample) begin
        idx <= (elem == LAST) ? '0 : elem + 1'b1;
      end
    end
  end

  // Scores and running signed maximum
  always_ff @(posedge clk) begin
    if (sample) begin
      triple.score[elem] <= pi_in;
      if (elem == '0) begin
        triple.score_max <= pi_in;
      end else if ($signed(pi_in) > $signed(triple.score_max)) begin
        triple.score_max <= pi_in;
      end
    end
  end

  // Head strobe only ever rides on a score strobe
  a_i_with_p : assert property (
    @(posedge clk) disable iff (reset) pi_in_i_enable |-> pi_in_p_enable
  ) else $error("pi_in_i_enable without pi_in_p_enable");

endmodule

`default_nettype wire

// File: dnc_mode_control.sv
// DNC read modes job sequencer: holds the head count and drives ready
`timescale 1ns/1ps
`default_nettype none

`include "dnc_read_modes_cfg.svh"

module dnc_mode_control (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    start,
  input  wire [`DNC_HEADS_W-1:0] size_r_in,
  input  wire                    head_done,
  output logic                   job_active,
  output logic                   ready
);

  // Heads still owed to the consumer
  logic [`DNC_HEADS_W-1:0] heads_left;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready      <= 1'b1;
      heads_left <= '0;
    end else if (ready) begin
      // Latch the job size, busy from next cycle
      if (start) begin
        ready      <= 1'b0;
        heads_left <= size_r_in;
      end
    end else if (heads_left == '0) begin
      // Empty job, release at once
      ready <= 1'b1;
    end else if (head_done) begin
      heads_left <= heads_left - 1'b1;
      // Last head out, ready in the following cycle
      if (heads_left == `DNC_HEADS_W'(1)) begin
        ready <= 1'b1;
      end
    end
  end

  // Capture only listens while a job is open
  assign job_active = ~ready;

  // Producer waits for ready before a new job
  a_no_start_busy : assert property (
    @(posedge clk) disable iff (reset) start |-> ready
  ) else $error("start while a job is running");

endmodule

`default_nettype wire

// File: dnc_read_modes_pkg.sv
// DNC read modes types: stage payload structs and the 2^(-k/16) table
`default_nettype none

`include "dnc_read_modes_cfg.svh"

package dnc_read_modes_pkg;

  // Three scores of one head plus their maximum
  typedef struct packed {
    logic [`DNC_MODES-1:0][`DNC_SCORE_W-1:0] score;
    logic [`DNC_SCORE_W-1:0]                 score_max;
  } mode_triple_t;

  // Base-2 exponents, one per mode
  typedef struct packed {
    logic [`DNC_MODES-1:0][`DNC_EXP_W-1:0] e;
  } mode_exp_t;

  // Exponents travel beside the reciprocal of their sum
  typedef struct packed {
    mode_exp_t              exps;
    logic [`DNC_EXP_W-1:0] recip;
  } mode_norm_t;

  ////////////////////
  // Power-of-two table
  ////////////////////

  // Entry k is round(65536 * 2^(-k/16))
  // Fraction of the exponent picks the entry, integer part shifts it
  localparam logic [`DNC_EXP_W-1:0] pow2_lut [16] = '{
    65536,
    62757,
    60097,
    57549,
    55109,
    52773,
    50535,
    48393,
    46341,
    44376,
    42495,
    40693,
    38968,
    37316,
    35734,
    34219
  };

endpackage

`default_nettype wire

// File: dnc_read_modes_cfg.svh
// DNC read modes configuration: fixed point widths, mode count and divider depth
`ifndef DNC_READ_MODES_CFG_SVH
`define DNC_READ_MODES_CFG_SVH

////////////////////
// Input side
////////////////////

// Signed Q8.8 mode scores
`define DNC_SCORE_W 16

// Backward, content, forward
`define DNC_MODES 3

// Head count of one job
`define DNC_HEADS_W 8

////////////////////
// Exponent path
////////////////////

// Unsigned exponent, 65536 stands for 1.0
`define DNC_EXP_W 17

// log2(e) in Q8.8
`define DNC_LOG2E 369

// Quotient bits of floor(2^32 / sum)
`define DNC_RECIP_STEPS 17

// Unsigned Q0.16 read mode, saturated at 65535
`define DNC_PI_W 16

`endif
